// ==== files.f ====
+incdir+hw
hw/fe_pkg.sv
hw/ic_fetch_if.sv
hw/fetch_ctrl.sv
hw/fetch_pc.sv
hw/icache.sv
hw/inst_buffer.sv
hw/frontend_top.sv
dv/frontend_props.sv
dv/frontend_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
  -f files.f -o frontend_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/frontend_sim)
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}

// ==== dv/frontend_vectors.txt ====
// word 0 is the key, every memory word holds its address xor key; word 1 is the event count
// then one event per line: kind cause commit_pc mtvec stvec mepc medeleg flags exp_pc count
// kind f is reset only; flags 1 fence.i, 2 ready stalls, 4 mem stalls, 8 no mem req, 10 mem req
13579bdf
00000008
// reset, cold misses under memory stalls
f 0 0000 0000 0000 0000 0000 04 1000 10
// jump back into fetched lines, all hits
0 0 1000 0000 0000 0000 0000 08 1000 4
// fence.i then the same lines again
0 0 1000 0000 0000 0000 0000 11 1000 4
// silent flush, target has word offset 4
1 0 2000 0000 0000 0000 0000 00 2004 6
// mret
2 0 0000 0000 0000 3000 0000 00 3000 5
// trap ecall_u delegated
3 8 0000 5000 4000 0000 0100 00 4000 4
// trap ecall_u not delegated
3 8 0000 5000 4000 0000 0000 00 5000 4
// jump mid-line with ready and memory stalls
0 0 600c 0000 0000 0000 0000 06 600c c

// ==== dv/frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module frontend_tb;
  import fe_pkg::*;

  localparam int          EV_WORDS  = 10;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_commit_valid;
  commit_kind_t             i_commit_kind;
  logic [`FE_ADDR_W-1:0]    i_commit_pc;
  trap_cause_t              i_commit_cause;
  logic [`FE_ADDR_W-1:0]    i_mtvec;
  logic [`FE_ADDR_W-1:0]    i_stvec;
  logic [`FE_ADDR_W-1:0]    i_mepc;
  logic [`FE_MEDELEG_W-1:0] i_medeleg;
  logic                     i_fence_i;
  logic                     o_mem_req_valid;
  logic                     i_mem_req_ready;
  logic [`FE_ADDR_W-1:0]    o_mem_req_addr;
  logic                     i_mem_resp_valid;
  logic [`FE_LINE_W-1:0]    i_mem_resp_data;
  logic                     o_inst_valid;
  logic                     i_inst_ready;
  logic [`FE_ADDR_W-1:0]    o_inst_pc;
  logic [31:0]              o_inst_data;

  logic [31:0] vec_mem [256];
  logic [31:0] key;
  logic [31:0] lfsr_state;
  logic [31:0] exp_pc;
  logic [31:0] mem_addr;
  int          num_events;
  int          errors;
  int          checks;
  int          remaining;
  int          mem_reqs;
  int          mem_wait;
  logic        mem_busy;
  logic        stall_ready;
  logic        stall_mem;
  logic        pend_commit;
  logic        pend_fence;
  logic        loaded;

  frontend_top u_frontend_top (.*);

  bind frontend_top frontend_props u_frontend_props (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_commit_valid(i_commit_valid),
    .o_inst_valid(o_inst_valid), .i_inst_ready(i_inst_ready), .o_inst_pc(o_inst_pc),
    .o_mem_req_valid(o_mem_req_valid), .i_mem_req_ready(i_mem_req_ready),
    .o_mem_req_addr(o_mem_req_addr), .i_mem_resp_valid(i_mem_resp_valid)
  );

  always #2 i_clk = ~i_clk;

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ LFSR_TAPS;
    return b;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return addr ^ key;
  endfunction

  function automatic logic [31:0] redirect_target(input logic [3:0] kind,
      input logic [3:0] cause, input logic [31:0] pc, input logic [31:0] mtvec,
      input logic [31:0] stvec, input logic [31:0] mepc, input logic [31:0] medeleg);
    case (kind)
      4'd0:    return pc;
      4'd1:    return pc + 32'd4;   // silent flush resumes after the committed pc
      4'd2:    return mepc;
      default: return medeleg[cause] ? stvec : mtvec;
    endcase
  endfunction

  // ====================
  // per-cycle models

  task automatic memory_model();
    logic [1:0] delay;
    i_mem_resp_valid = 1'b0;
    if (mem_busy) begin
      if (mem_wait == 0) begin
        i_mem_resp_valid = 1'b1;
        i_mem_resp_data  = {word_at(mem_addr + 32'd4), word_at(mem_addr)};
        mem_busy         = 1'b0;
      end else begin
        mem_wait--;
      end
    end
    i_mem_req_ready = stall_mem ? lfsr_bit() : 1'b1;
    if (o_mem_req_valid && i_mem_req_ready) begin
      delay[1] = lfsr_bit();
      delay[0] = lfsr_bit();
      mem_busy = 1'b1;
      mem_addr = o_mem_req_addr;
      mem_wait = int'(delay);   // answer 1 to 4 cycles later
      mem_reqs++;
    end
  endtask

  task automatic inst_port();
    i_inst_ready = (remaining > 0) && (stall_ready ? lfsr_bit() : 1'b1);
    if (o_inst_valid && i_inst_ready) begin
      checks++;
      assert (o_inst_pc == exp_pc) else begin
        errors++;
        $display("Error: o_inst_pc got %h expected %h", o_inst_pc, exp_pc);
      end
      assert (o_inst_data == word_at(exp_pc)) else begin
        errors++;
        $display("Error: o_inst_data got %h expected %h", o_inst_data, word_at(exp_pc));
      end
      exp_pc = exp_pc + 32'd4;
      remaining--;
    end
  endtask

  task automatic step_cycle();
    @(posedge i_clk);
    #0.5;
    i_commit_valid = pend_commit;
    i_fence_i      = pend_fence;
    pend_commit    = 1'b0;
    pend_fence     = 1'b0;
    memory_model();
    inst_port();
  endtask

  // ====================
  // events

  task automatic run_event(input int e);
    logic [31:0] flags;
    logic [31:0] target;
    int          base;
    base        = 2 + e * EV_WORDS;
    flags       = vec_mem[base+7];
    stall_ready = flags[1];
    stall_mem   = flags[2];
    repeat (20) step_cycle();   // let prefetch settle
    i_commit_kind  = commit_kind_t'(vec_mem[base][1:0]);
    i_commit_cause = trap_cause_t'(vec_mem[base+1][3:0]);
    i_commit_pc    = vec_mem[base+2];
    i_mtvec        = vec_mem[base+3];
    i_stvec        = vec_mem[base+4];
    i_mepc         = vec_mem[base+5];
    i_medeleg      = vec_mem[base+6][`FE_MEDELEG_W-1:0];
    if (flags[0]) begin
      pend_fence = 1'b1;
      step_cycle();
    end
    if (vec_mem[base] != 32'hf) begin
      target = redirect_target(vec_mem[base][3:0], vec_mem[base+1][3:0], vec_mem[base+2],
                               vec_mem[base+3], vec_mem[base+4], vec_mem[base+5],
                               vec_mem[base+6]);
      assert (target == vec_mem[base+8]) else begin
        errors++;
        $display("Error: redirect target got %h expected %h", target, vec_mem[base+8]);
      end
      pend_commit = 1'b1;
      step_cycle();
    end
    mem_reqs  = 0;   // only requests of the new path
    exp_pc    = vec_mem[base+8];
    remaining = int'(vec_mem[base+9]);
    while (remaining > 0) step_cycle();
    if (flags[3]) begin
      assert (mem_reqs == 0) else begin
        errors++;
        $display("replay of cached lines in event %0d made %0d memory requests", e, mem_reqs);
      end
    end
    if (flags[4]) begin
      assert (mem_reqs > 0) else begin
        errors++;
        $display("refetch after fence.i in event %0d made no memory request", e);
      end
    end
  endtask

  initial begin
    i_clk            = 1'b0;
    i_reset_n        = 1'b0;
    i_commit_valid   = 1'b0;
    i_commit_kind    = JUMP;
    i_commit_pc      = '0;
    i_commit_cause   = ILLEGAL_INST;
    i_mtvec          = '0;
    i_stvec          = '0;
    i_mepc           = '0;
    i_medeleg        = '0;
    i_fence_i        = 1'b0;
    i_mem_req_ready  = 1'b0;
    i_mem_resp_valid = 1'b0;
    i_mem_resp_data  = '0;
    i_inst_ready     = 1'b0;
    lfsr_state       = 32'hc8af_4c6c;
    errors           = 0;
    checks           = 0;
    remaining        = 0;
    mem_reqs         = 0;
    mem_wait         = 0;
    mem_busy         = 1'b0;
    stall_ready      = 1'b0;
    stall_mem        = 1'b0;
    pend_commit      = 1'b0;
    pend_fence       = 1'b0;
    loaded           = 1'b0;
    mem_addr = '0;
    exp_pc   = '0;
    $readmemh("dv/frontend_vectors.txt", vec_mem);
    key        = vec_mem[0];
    num_events = int'(vec_mem[1]);
    loaded     = 1'b1;
    repeat (2) @(posedge i_clk);
    #0.5;
    i_reset_n = 1'b1;
    for (int e = 0; e < num_events; e++) run_event(e);
    repeat (4) step_cycle();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (loaded);
    repeat (200 * num_events + 400) @(posedge i_clk);
    $display("timeout, the instruction stream did not complete in time");
    $display("checks %0d, errors %0d", checks, errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/frontend_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module frontend_props (
  input logic                  i_clk,
  input logic                  i_reset_n,
  input logic                  i_commit_valid,
  input logic                  o_inst_valid,
  input logic                  i_inst_ready,
  input logic [`FE_ADDR_W-1:0] o_inst_pc,
  input logic                  o_mem_req_valid,
  input logic                  i_mem_req_ready,
  input logic [`FE_ADDR_W-1:0] o_mem_req_addr,
  input logic                  i_mem_resp_valid
);

  logic r_outstanding;   // request accepted, line not back yet

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_outstanding <= 1'b0;
    end else if (o_mem_req_valid && i_mem_req_ready) begin
      r_outstanding <= 1'b1;
    end else if (i_mem_resp_valid) begin
      r_outstanding <= 1'b0;
    end
  end

  // ====================
  // handshakes

  // a flush may drop a waiting instruction
  inst_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_inst_valid && !i_inst_ready && !i_commit_valid) |=>
    (o_inst_valid && $stable(o_inst_pc)))
    else $error("instruction dropped or changed before it was taken");

  mem_req_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_mem_req_valid && !i_mem_req_ready) |=>
    (o_mem_req_valid && $stable(o_mem_req_addr)))
    else $error("memory request dropped or changed before it was accepted");

  mem_req_single: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_mem_req_valid |-> !r_outstanding)
    else $error("second memory request while one is outstanding");

endmodule

`default_nettype wire

// ==== hw/frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module frontend_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  // commit and csr
  input  logic                     i_commit_valid,
  input  fe_pkg::commit_kind_t     i_commit_kind,
  input  logic [`FE_ADDR_W-1:0]    i_commit_pc,
  input  fe_pkg::trap_cause_t      i_commit_cause,
  input  logic [`FE_ADDR_W-1:0]    i_mtvec,
  input  logic [`FE_ADDR_W-1:0]    i_stvec,
  input  logic [`FE_ADDR_W-1:0]    i_mepc,
  input  logic [`FE_MEDELEG_W-1:0] i_medeleg,

  input  logic                     i_fence_i,

  // memory
  output logic                     o_mem_req_valid,
  input  logic                     i_mem_req_ready,
  output logic [`FE_ADDR_W-1:0]    o_mem_req_addr,
  input  logic                     i_mem_resp_valid,
  input  logic [`FE_LINE_W-1:0]    i_mem_resp_data,

  // instruction out
  output logic                     o_inst_valid,
  input  logic                     i_inst_ready,
  output logic [`FE_ADDR_W-1:0]    o_inst_pc,
  output logic [31:0]              o_inst_data
);
  import fe_pkg::*;

  ic_addr_u              w_fetch_addr;
  logic                  w_buf_space;
  logic                  w_redirect_valid;
  logic [`FE_ADDR_W-1:0] w_redirect_addr;
  logic                  w_issue;
  logic                  w_reload_miss;
  logic                  w_flush;

  ic_fetch_if u_ic_if ();

  fetch_ctrl u_fetch_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_commit_valid   (i_commit_valid),
    .i_commit_kind    (i_commit_kind),
    .i_commit_pc      (i_commit_pc),
    .i_commit_cause   (i_commit_cause),
    .i_mtvec          (i_mtvec),
    .i_stvec          (i_stvec),
    .i_mepc           (i_mepc),
    .i_medeleg        (i_medeleg),
    .i_buf_space      (w_buf_space),
    .i_fetch_addr     (w_fetch_addr),
    .o_redirect_valid (w_redirect_valid),
    .o_redirect_addr  (w_redirect_addr),
    .o_issue          (w_issue),
    .o_reload_miss    (w_reload_miss),
    .o_flush          (w_flush),
    .ic               (u_ic_if)
  );

  fetch_pc u_fetch_pc (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_issue          (w_issue),
    .i_reload_miss    (w_reload_miss),
    .i_miss_addr      (u_ic_if.resp_addr.raw),
    .i_redirect_valid (w_redirect_valid),
    .i_redirect_addr  (w_redirect_addr),
    .o_fetch_addr     (w_fetch_addr)
  );

  icache u_icache (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_fence_i        (i_fence_i),
    .ic               (u_ic_if),
    .o_mem_req_valid  (o_mem_req_valid),
    .i_mem_req_ready  (i_mem_req_ready),
    .o_mem_req_addr   (o_mem_req_addr),
    .i_mem_resp_valid (i_mem_resp_valid),
    .i_mem_resp_data  (i_mem_resp_data)
  );

  // hit lines go straight into the buffer
  inst_buffer u_inst_buffer (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_flush          (w_flush),
    .i_line_valid     (u_ic_if.resp_valid),
    .i_line_addr      (u_ic_if.resp_addr),
    .i_line_data      (u_ic_if.resp_line),
    .o_space          (w_buf_space),
    .o_inst_valid     (o_inst_valid),
    .i_inst_ready     (i_inst_ready),
    .o_inst_pc        (o_inst_pc),
    .o_inst_data      (o_inst_data)
  );

endmodule

`default_nettype wire

// ==== hw/inst_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module inst_buffer (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_flush,

  input  logic                  i_line_valid,
  input  fe_pkg::ic_addr_u      i_line_addr,
  input  logic [`FE_LINE_W-1:0] i_line_data,
  output logic                  o_space,

  output logic                  o_inst_valid,
  input  logic                  i_inst_ready,
  output logic [`FE_ADDR_W-1:0] o_inst_pc,
  output logic [31:0]           o_inst_data
);
  import fe_pkg::*;

  localparam int PTR_W  = $clog2(`FE_BUF_DEPTH);
  localparam int CNT_W  = $clog2(`FE_BUF_DEPTH + 1);
  localparam int WORD_W = $clog2(`FE_LINE_WORDS);

  ic_addr_u              r_addr [`FE_BUF_DEPTH];
  logic [`FE_LINE_W-1:0] r_data [`FE_BUF_DEPTH];
  logic [PTR_W-1:0]      r_wr_ptr;
  logic [PTR_W-1:0]      r_rd_ptr;
  logic [CNT_W-1:0]      r_count;
  logic [WORD_W-1:0]     r_head_word;   // lowest word still owed from head line
  logic [WORD_W-1:0]     w_start_word;
  logic [WORD_W-1:0]     w_word;
  logic                  w_take;
  logic                  w_pop;

  // target lines may start mid-line
  assign w_start_word = r_addr[r_rd_ptr].raw[`FE_IC_OFS_W-1:2];
  assign w_word       = (r_head_word > w_start_word) ? r_head_word : w_start_word;

  assign o_inst_valid = (r_count != '0);
  assign o_inst_pc    = {r_addr[r_rd_ptr].raw[`FE_ADDR_W-1:`FE_IC_OFS_W], w_word, 2'b00};
  assign o_inst_data  = r_data[r_rd_ptr][w_word*32 +: 32];
  // room for one more issue on top of the one in flight
  assign o_space      = (r_count <= CNT_W'(`FE_BUF_DEPTH - 2));

  assign w_take = o_inst_valid && i_inst_ready;
  assign w_pop  = w_take && (w_word == WORD_W'(`FE_LINE_WORDS - 1));

  always_ff @(posedge i_clk) begin
    if (i_line_valid && !i_flush) begin
      r_addr[r_wr_ptr] <= i_line_addr;
      r_data[r_wr_ptr] <= i_line_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr    <= '0;
      r_rd_ptr    <= '0;
      r_count     <= '0;
      r_head_word <= '0;
    end else if (i_flush) begin
      r_wr_ptr    <= '0;
      r_rd_ptr    <= '0;
      r_count     <= '0;
      r_head_word <= '0;
    end else begin
      if (i_line_valid) r_wr_ptr <= r_wr_ptr + PTR_W'(1);
      if (w_pop) r_rd_ptr <= r_rd_ptr + PTR_W'(1);
      r_count <= r_count + CNT_W'(i_line_valid) - CNT_W'(w_pop);
      if (w_pop) begin
        r_head_word <= '0;
      end else if (w_take) begin
        r_head_word <= w_word + WORD_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module icache (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_fence_i,

  ic_fetch_if.cache             ic,

  output logic                  o_mem_req_valid,
  input  logic                  i_mem_req_ready,
  output logic [`FE_ADDR_W-1:0] o_mem_req_addr,
  input  logic                  i_mem_resp_valid,
  input  logic [`FE_LINE_W-1:0] i_mem_resp_data
);
  import fe_pkg::*;

  // ====================
  // arrays

  logic [`FE_IC_TAG_W-1:0] r_tag  [`FE_IC_SETS];
  logic [`FE_LINE_W-1:0]   r_data [`FE_IC_SETS];
  logic [`FE_IC_SETS-1:0]  r_valid;

  // s1 lookup
  logic     r_s1_valid;
  ic_addr_u r_s1_addr;
  logic     w_s1_hit;
  logic     w_s1_miss;

  // refill
  logic     r_fill_busy;
  logic     r_mem_req_valid;
  logic     r_fill_done;
  ic_addr_u r_fill_addr;
  logic     w_fill_write;
  logic     r_fence_pend;
  logic     w_fence_go;

  assign w_s1_hit  = r_valid[r_s1_addr.f.index] &&
                     (r_tag[r_s1_addr.f.index] == r_s1_addr.f.tag);
  assign w_s1_miss = r_s1_valid && !w_s1_hit && !ic.kill;

  assign ic.req_ready  = !r_fill_busy && !w_s1_miss;
  assign ic.resp_valid = r_s1_valid && w_s1_hit && !ic.kill;
  assign ic.resp_miss  = w_s1_miss;
  assign ic.resp_addr  = r_s1_addr;
  assign ic.resp_line  = r_data[r_s1_addr.f.index];
  assign ic.fill_done  = r_fill_done;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
    end else begin
      r_s1_valid <= ic.req_valid && ic.req_ready;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ic.req_valid && ic.req_ready) r_s1_addr <= ic.req_addr;
    if (w_s1_miss) r_fill_addr <= r_s1_addr;
  end

  // ====================
  // refill sequence

  assign w_fill_write = r_fill_busy && !r_mem_req_valid && i_mem_resp_valid;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_fill_busy     <= 1'b0;
      r_mem_req_valid <= 1'b0;
      r_fill_done     <= 1'b0;
    end else begin
      r_fill_done <= w_fill_write;   // one-cycle pulse
      if (w_s1_miss) begin
        r_fill_busy     <= 1'b1;
        r_mem_req_valid <= 1'b1;
      end else if (r_mem_req_valid && i_mem_req_ready) begin
        r_mem_req_valid <= 1'b0;
      end else if (w_fill_write) begin
        r_fill_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fill_write) begin
      r_tag[r_fill_addr.f.index]  <= r_fill_addr.f.tag;
      r_data[r_fill_addr.f.index] <= i_mem_resp_data;
    end
  end

  assign o_mem_req_valid = r_mem_req_valid;
  assign o_mem_req_addr  = r_fill_addr.raw & ~`FE_ADDR_W'(`FE_LINE_BYTES - 1);

  // valid bits, fence.i waits out a running refill
  assign w_fence_go = (i_fence_i || r_fence_pend) && !r_fill_busy;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid      <= '0;
      r_fence_pend <= 1'b0;
    end else if (w_fence_go) begin
      r_valid      <= '0;
      r_fence_pend <= 1'b0;
    end else begin
      if (i_fence_i) r_fence_pend <= 1'b1;
      if (w_fill_write) r_valid[r_fill_addr.f.index] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module fetch_pc (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_issue,
  input  logic                  i_reload_miss,
  input  logic [`FE_ADDR_W-1:0] i_miss_addr,
  input  logic                  i_redirect_valid,
  input  logic [`FE_ADDR_W-1:0] i_redirect_addr,

  output fe_pkg::ic_addr_u      o_fetch_addr
);
  import fe_pkg::*;

  ic_addr_u r_addr;
  ic_addr_u w_next_line;

  // next line boundary, drops any word offset
  assign w_next_line.raw = (r_addr.raw & ~`FE_ADDR_W'(`FE_LINE_BYTES - 1)) +
                           `FE_ADDR_W'(`FE_LINE_BYTES);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_addr.raw <= `FE_PC_INIT;
    end else if (i_redirect_valid) begin
      r_addr.raw <= i_redirect_addr;
    end else if (i_reload_miss) begin
      r_addr.raw <= i_miss_addr;   // back to the missed line
    end else if (i_issue) begin
      r_addr <= w_next_line;
    end
  end

  assign o_fetch_addr = r_addr;

endmodule

`default_nettype wire

// ==== hw/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

module fetch_ctrl (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_commit_valid,
  input  fe_pkg::commit_kind_t     i_commit_kind,
  input  logic [`FE_ADDR_W-1:0]    i_commit_pc,
  input  fe_pkg::trap_cause_t      i_commit_cause,

  input  logic [`FE_ADDR_W-1:0]    i_mtvec,
  input  logic [`FE_ADDR_W-1:0]    i_stvec,
  input  logic [`FE_ADDR_W-1:0]    i_mepc,
  input  logic [`FE_MEDELEG_W-1:0] i_medeleg,

  input  logic                     i_buf_space,
  input  fe_pkg::ic_addr_u         i_fetch_addr,

  output logic                     o_redirect_valid,
  output logic [`FE_ADDR_W-1:0]    o_redirect_addr,
  output logic                     o_issue,
  output logic                     o_reload_miss,
  output logic                     o_flush,

  ic_fetch_if.ctrl                 ic
);
  import fe_pkg::*;

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    ISSUED    = 2'd1,
    WAIT_FILL = 2'd2,
    WAIT_BUF  = 2'd3
  } fetch_state_t;

  fetch_state_t          r_state;
  fetch_state_t          w_state_next;
  logic [`FE_ADDR_W-1:0] w_target;

  // ====================
  // redirect target

  always_comb begin
    case (i_commit_kind)
      JUMP:         w_target = i_commit_pc;
      SILENT_FLUSH: w_target = i_commit_pc + `FE_ADDR_W'(4);
      MRET:         w_target = i_mepc;
      TRAP: begin
        if (i_medeleg[i_commit_cause]) begin
          w_target = i_stvec;   // delegated to S
        end else begin
          w_target = i_mtvec;
        end
      end
      default:      w_target = i_commit_pc;
    endcase
  end

  // ====================
  // fetch FSM

  always_comb begin
    w_state_next = r_state;
    if (i_commit_valid) begin
      // a refill in progress lands before the target is fetched
      if ((r_state == WAIT_FILL) && !ic.fill_done) begin
        w_state_next = WAIT_FILL;
      end else begin
        w_state_next = ISSUED;
      end
    end else begin
      case (r_state)
        IDLE:      w_state_next = ISSUED;
        ISSUED: begin
          if (ic.resp_miss) begin
            w_state_next = WAIT_FILL;
          end else if (!i_buf_space) begin
            w_state_next = WAIT_BUF;
          end
        end
        WAIT_FILL: if (ic.fill_done) w_state_next = ISSUED;
        WAIT_BUF: begin
          if (ic.resp_miss) begin
            w_state_next = WAIT_FILL;   // last request before the stall missed
          end else if (i_buf_space) begin
            w_state_next = ISSUED;
          end
        end
        default:   w_state_next = IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
    end else begin
      r_state <= w_state_next;
    end
  end

  assign ic.req_valid = (r_state == ISSUED) && i_buf_space && !i_commit_valid;
  assign ic.req_addr  = i_fetch_addr;
  assign ic.kill      = i_commit_valid;   // in-flight line is old path

  assign o_issue          = ic.req_valid && ic.req_ready;
  assign o_reload_miss    = ic.resp_miss;
  assign o_redirect_valid = i_commit_valid;
  assign o_redirect_addr  = w_target;
  assign o_flush          = i_commit_valid;

endmodule

`default_nettype wire

// ==== hw/ic_fetch_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fe_defines.svh"

interface ic_fetch_if;
  import fe_pkg::*;

  // request
  logic                  req_valid;
  logic                  req_ready;  // low during refill
  ic_addr_u              req_addr;
  logic                  kill;       // drops the s1 response

  // response
  logic                  resp_valid;
  logic                  resp_miss;
  ic_addr_u              resp_addr;
  logic [`FE_LINE_W-1:0] resp_line;
  logic                  fill_done;

  modport ctrl (
    output req_valid, req_addr, kill,
    input  req_ready, resp_valid, resp_miss, resp_addr, resp_line, fill_done
  );

  modport cache (
    input  req_valid, req_addr, kill,
    output req_ready, resp_valid, resp_miss, resp_addr, resp_line, fill_done
  );

endinterface

`default_nettype wire

// ==== hw/fe_pkg.sv ====
`default_nettype none

`include "fe_defines.svh"

package fe_pkg;

  // ====================
  // commit side

  typedef enum logic [1:0] {
    JUMP         = 2'd0,
    SILENT_FLUSH = 2'd1,
    MRET         = 2'd2,
    TRAP         = 2'd3
  } commit_kind_t;

  // exception codes, value doubles as medeleg bit index
  typedef enum logic [3:0] {
    INST_ADDR_MISALIGN  = 4'd0,
    INST_ACC_FAULT      = 4'd1,
    ILLEGAL_INST        = 4'd2,
    BREAKPOINT          = 4'd3,
    LOAD_ADDR_MISALIGN  = 4'd4,
    LOAD_ACC_FAULT      = 4'd5,
    STAMO_ADDR_MISALIGN = 4'd6,
    STAMO_ACC_FAULT     = 4'd7,
    ECALL_U             = 4'd8,
    ECALL_S             = 4'd9,
    ECALL_M             = 4'd11,
    INST_PAGE_FAULT     = 4'd12,
    LOAD_PAGE_FAULT     = 4'd13,
    STAMO_PAGE_FAULT    = 4'd15
  } trap_cause_t;

  // ====================
  // fetch address views

  typedef struct packed {
    logic [`FE_IC_TAG_W-1:0] tag;
    logic [`FE_IC_IDX_W-1:0] index;
    logic [`FE_IC_OFS_W-1:0] offset;
  } ic_addr_s;

  typedef union packed {
    logic [`FE_ADDR_W-1:0] raw;
    ic_addr_s              f;     // cache lookup fields
  } ic_addr_u;

endpackage

`default_nettype wire

// ==== hw/fe_defines.svh ====
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// fetch address and pc
`define FE_ADDR_W      32
`define FE_PC_INIT     32'h0000_1000

// icache geometry, two instructions per line
`define FE_LINE_BYTES  8
`define FE_LINE_W      (`FE_LINE_BYTES * 8)
`define FE_LINE_WORDS  (`FE_LINE_BYTES / 4)
`define FE_IC_SETS     16
`define FE_IC_OFS_W    ($clog2(`FE_LINE_BYTES))
`define FE_IC_IDX_W    ($clog2(`FE_IC_SETS))
`define FE_IC_TAG_W    (`FE_ADDR_W - `FE_IC_IDX_W - `FE_IC_OFS_W)

// instruction buffer, in lines
`define FE_BUF_DEPTH   4

// one delegation bit per trap cause code
`define FE_MEDELEG_W   16

`endif
